/* hdl/uartPkg.sv */
// Shared types and constants of the UART controller
// Register map is flat, 3-bit address, 8-bit data

package uartPkg;

    // ----------------------------------------
    // Bus and datapath types
    // ----------------------------------------

    // Wishbone classic request, host to device
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [2:0] adr;
        logic [7:0] dat;
    } wbReq_t;

    // Wishbone classic response, device to host
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wbRsp_t;

    // Live configuration seen by the datapath
    typedef struct packed {
        logic [15:0] period;
        logic [3:0]  roundUp;
        logic [3:0]  roundDown;
        logic        parEn;
        logic        parOdd;
        logic        msbFirst;
        logic        loopback;
        logic        txEn;
        logic        rxEn;
    } uartCfg_t;

    // One received byte plus its error flags
    typedef struct packed {
        logic [7:0] data;
        logic       parErr;
        logic       frameErr;
    } rxWord_t;

    // ----------------------------------------
    // Register addresses
    // ----------------------------------------
    localparam logic [2:0] ADDR_CONTROL   = 3'd0;
    localparam logic [2:0] ADDR_MODE      = 3'd1;
    localparam logic [2:0] ADDR_BAUD_HIGH = 3'd2;
    localparam logic [2:0] ADDR_BAUD_LOW  = 3'd3;
    localparam logic [2:0] ADDR_COMP      = 3'd4;
    localparam logic [2:0] ADDR_STATUS    = 3'd5;
    localparam logic [2:0] ADDR_RSVD      = 3'd6;
    localparam logic [2:0] ADDR_DATA      = 3'd7;

    // Reset values
    localparam logic [15:0] RST_PERIOD     = 16'd20;
    localparam logic [3:0]  RST_ROUND_UP   = 4'd10;
    localparam logic [3:0]  RST_ROUND_DOWN = 4'd5;
    // Parity on, odd, LSB first, no loopback
    localparam logic [7:0]  RST_MODE       = 8'h60;

    // FIFO geometry
    localparam int FIFO_AW    = 3;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    // Status register bit positions
    localparam int STAT_PAR_ERR   = 6;
    localparam int STAT_FRAME_ERR = 5;
    localparam int STAT_TX_FULL   = 4;
    localparam int STAT_TX_EMPTY  = 3;
    localparam int STAT_RX_FULL   = 2;
    localparam int STAT_RX_EMPTY  = 1;
    localparam int STAT_RX_OVR    = 0;

endpackage

/* hdl/syncFifo.sv */
// Single-clock first-word-fall-through FIFO
// Push when full and pop when empty are ignored
`timescale 1ns/1ps

module syncFifo import uartPkg::*; #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     clr_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t head_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wrPtr;
    logic [AW-1:0]   rdPtr;
    logic [CW-1:0]   count;
    logic            doPush;
    logic            doPop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign doPush  = push_i && !full_o;
    assign doPop   = pop_i && !empty_o;
    // Head visible without a pop
    assign head_o  = mem[rdPtr];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clr_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)  rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            count <= count + CW'(doPush) - CW'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush && !clr_i) begin
            mem[wrPtr] <= data_i;
        end
    end

endmodule

/* hdl/baudGen.sv */
// Compensated bit timer, one bit = roundUp*(period+1) + roundDown*period clocks
// roundUp + roundDown must be nonzero
`timescale 1ns/1ps

module baudGen (
    input  logic        clk,
    input  logic        rst,
    input  logic        run_i,
    input  logic [15:0] period_i,
    input  logic [3:0]  roundUp_i,
    input  logic [3:0]  roundDown_i,
    output logic        midTick_o,
    output logic        bitTick_o
);

    logic [15:0] clkCnt;
    logic [4:0]  tickCnt;
    logic [4:0]  nTicks;
    logic [4:0]  midIdx;
    logic [15:0] limit;
    logic        tick;
    logic        lastTick;

    // Acquisition periods per bit and the one that marks mid-bit
    assign nTicks = {1'b0, roundUp_i} + {1'b0, roundDown_i};
    assign midIdx = (nTicks + 5'd1) >> 1;

    // Round-up periods come first and last one clock longer
    assign limit    = (tickCnt < {1'b0, roundUp_i}) ? period_i : period_i - 16'd1;
    assign tick     = run_i && (clkCnt == limit);
    assign lastTick = (tickCnt == nTicks - 5'd1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            clkCnt  <= '0;
            tickCnt <= '0;
        end else if (!run_i) begin
            // Held at zero between frames
            clkCnt  <= '0;
            tickCnt <= '0;
        end else if (tick) begin
            clkCnt  <= '0;
            tickCnt <= lastTick ? 5'd0 : tickCnt + 5'd1;
        end else begin
            clkCnt <= clkCnt + 16'd1;
        end
    end

    assign midTick_o = tick && ((tickCnt + 5'd1) == midIdx);
    assign bitTick_o = tick && lastTick;

endmodule

/* hdl/uartTx.sv */
// Transmit serializer, 8 data bits, optional parity, one stop bit
// A frame in progress always completes, even if TxEn drops
`timescale 1ns/1ps

module uartTx import uartPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  uartCfg_t   cfg_i,
    input  logic [7:0] fifoData_i,
    input  logic       fifoEmpty_i,
    output logic       fifoPop_o,
    input  logic       bitTick_i,
    output logic       run_o,
    output logic       txd_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } txState_t;

    txState_t   state;
    logic [2:0] bitCnt;
    logic       parAcc;
    logic [7:0] shiftReg;
    logic       txBit;

    // Start a frame as soon as a byte is waiting
    assign fifoPop_o = (state == TX_IDLE) && cfg_i.txEn && !fifoEmpty_i;
    assign run_o     = (state != TX_IDLE);
    assign txBit     = cfg_i.msbFirst ? shiftReg[7] : shiftReg[0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= TX_IDLE;
            bitCnt <= '0;
            parAcc <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (fifoPop_o) begin
                        state  <= TX_START;
                        bitCnt <= '0;
                        // Seeding with parOdd gives odd parity directly
                        parAcc <= cfg_i.parOdd;
                    end
                end
                TX_START: if (bitTick_i) state <= TX_DATA;
                TX_DATA: begin
                    if (bitTick_i) begin
                        parAcc <= parAcc ^ txBit;
                        bitCnt <= bitCnt + 3'd1;
                        if (bitCnt == 3'd7) begin
                            state <= cfg_i.parEn ? TX_PARITY : TX_STOP;
                        end
                    end
                end
                TX_PARITY: if (bitTick_i) state <= TX_STOP;
                default: if (bitTick_i) state <= TX_IDLE;
            endcase
        end
    end

    // Shift register, direction follows msbFirst
    always_ff @(posedge clk) begin
        if (fifoPop_o) begin
            shiftReg <= fifoData_i;
        end else if (state == TX_DATA && bitTick_i) begin
            shiftReg <= cfg_i.msbFirst ? {shiftReg[6:0], 1'b0} : {1'b0, shiftReg[7:1]};
        end
    end

    // Line level per state
    always_comb begin
        case (state)
            TX_START:  txd_o = 1'b0;
            TX_DATA:   txd_o = txBit;
            TX_PARITY: txd_o = parAcc;
            default:   txd_o = 1'b1;
        endcase
    end

endmodule

/* hdl/uartRx.sv */
// Receive deserializer, samples each bit at its midTick
// Returns to idle at the stop-bit sample so back-to-back frames are caught
`timescale 1ns/1ps

module uartRx import uartPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  uartCfg_t cfg_i,
    input  logic     rxd_i,
    input  logic     midTick_i,
    input  logic     bitTick_i,
    output logic     run_o,
    output logic     push_o,
    output rxWord_t  word_o
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rxState_t;

    rxState_t   state;
    logic [2:0] rxSync;
    logic       line;
    logic       fall;
    logic [2:0] bitCnt;
    logic       parAcc;
    logic       parErr;
    logic [7:0] shiftReg;

    // ----------------------------------------
    // Line synchronizer and edge detect
    // ----------------------------------------
    // Two flops for metastability, third holds the previous level
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rxSync <= 3'b111;
        end else begin
            rxSync <= {rxSync[1:0], rxd_i};
        end
    end

    assign line  = rxSync[1];
    assign fall  = rxSync[2] && !rxSync[1];
    assign run_o = (state != RX_IDLE);

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    // Samples on midTick, moves to the next bit on bitTick
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= RX_IDLE;
            bitCnt <= '0;
            parAcc <= 1'b0;
            parErr <= 1'b0;
            push_o <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (!cfg_i.rxEn) begin
                state <= RX_IDLE;
            end else begin
                case (state)
                    RX_IDLE: begin
                        bitCnt <= '0;
                        parAcc <= 1'b0;
                        parErr <= 1'b0;
                        if (fall) state <= RX_START;
                    end
                    RX_START: begin
                        // A high mid sample means a glitch
                        if (midTick_i && line) begin
                            state <= RX_IDLE;
                        end else if (bitTick_i) begin
                            state <= RX_DATA;
                        end
                    end
                    RX_DATA: begin
                        if (midTick_i) parAcc <= parAcc ^ line;
                        if (bitTick_i) begin
                            bitCnt <= bitCnt + 3'd1;
                            if (bitCnt == 3'd7) begin
                                state <= cfg_i.parEn ? RX_PARITY : RX_STOP;
                            end
                        end
                    end
                    RX_PARITY: begin
                        // Total ones must be odd when parOdd is set
                        if (midTick_i) parErr <= parAcc ^ line ^ cfg_i.parOdd;
                        if (bitTick_i) state <= RX_STOP;
                    end
                    default: begin
                        if (midTick_i) begin
                            push_o <= 1'b1;
                            state  <= RX_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // Byte rebuild in the configured order
    always_ff @(posedge clk) begin
        if (state == RX_DATA && midTick_i) begin
            shiftReg <= cfg_i.msbFirst ? {shiftReg[6:0], line} : {line, shiftReg[7:1]};
        end
    end

    // Word captured at the stop sample, pushed on the next cycle
    always_ff @(posedge clk) begin
        if (state == RX_STOP && midTick_i) begin
            word_o <= '{data: shiftReg, parErr: parErr, frameErr: !line};
        end
    end

endmodule

/* hdl/uartRegs.sv */
// Wishbone classic slave with the UART register file
// One-cycle ack, master must drop stb before the next request
`timescale 1ns/1ps

module uartRegs import uartPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  wbReq_t     wbReq_i,
    output wbRsp_t     wbRsp_o,
    output uartCfg_t   cfg_o,
    output logic       txPush_o,
    output logic       txClr_o,
    output logic [7:0] txData_o,
    input  logic       txFull_i,
    input  logic       txEmpty_i,
    output logic       rxPop_o,
    output logic       rxClr_o,
    input  rxWord_t    rxHead_i,
    input  logic       rxEmpty_i,
    input  logic       rxFull_i,
    input  logic       rxDrop_i
);

    logic        valid;
    logic        take;
    logic        wrTake;
    logic        ack;
    logic        hold;
    logic [7:0]  rdMux;
    logic [7:0]  rdData;
    logic [7:0]  status;
    // Register contents
    logic        txEn;
    logic        rxEn;
    logic        msbFirst;
    logic        parEn;
    logic        parOdd;
    logic        loopback;
    logic [15:0] period;
    logic [3:0]  roundUp;
    logic [3:0]  roundDown;
    logic        rxOvr;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    assign valid  = wbReq_i.cyc && wbReq_i.stb;
    // New request only once the previous stb has dropped
    assign take   = valid && !ack && !hold;
    assign wrTake = take && wbReq_i.we;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack  <= 1'b0;
            hold <= 1'b0;
        end else begin
            ack  <= take;
            hold <= valid && (hold || ack);
        end
    end

    // Read data latched with the request, stable while ack is high
    always_ff @(posedge clk) begin
        if (take) begin
            rdData <= rdMux;
        end
    end

    assign wbRsp_o = '{ack: ack, dat: rdData};

    // FIFO strobes act on the edge where ack rises
    assign txPush_o = wrTake && (wbReq_i.adr == ADDR_DATA);
    assign txData_o = wbReq_i.dat;
    assign txClr_o  = wrTake && (wbReq_i.adr == ADDR_CONTROL) && wbReq_i.dat[0];
    assign rxClr_o  = wrTake && (wbReq_i.adr == ADDR_CONTROL) && wbReq_i.dat[1];
    assign rxPop_o  = take && !wbReq_i.we && (wbReq_i.adr == ADDR_DATA);

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            txEn      <= 1'b0;
            rxEn      <= 1'b0;
            msbFirst  <= RST_MODE[7];
            parEn     <= RST_MODE[6];
            parOdd    <= RST_MODE[5];
            loopback  <= RST_MODE[0];
            period    <= RST_PERIOD;
            roundUp   <= RST_ROUND_UP;
            roundDown <= RST_ROUND_DOWN;
        end else if (wrTake) begin
            case (wbReq_i.adr)
                ADDR_CONTROL: begin
                    rxEn <= wbReq_i.dat[3];
                    txEn <= wbReq_i.dat[2];
                end
                ADDR_MODE: begin
                    msbFirst <= wbReq_i.dat[7];
                    parEn    <= wbReq_i.dat[6];
                    parOdd   <= wbReq_i.dat[5];
                    loopback <= wbReq_i.dat[0];
                end
                ADDR_BAUD_HIGH: period[15:8] <= wbReq_i.dat;
                ADDR_BAUD_LOW:  period[7:0]  <= wbReq_i.dat;
                ADDR_COMP: begin
                    roundUp   <= wbReq_i.dat[7:4];
                    roundDown <= wbReq_i.dat[3:0];
                end
                default: ;
            endcase
        end
    end

    // Sticky overrun, a new drop wins over the clear
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rxOvr <= 1'b0;
        end else if (rxDrop_i) begin
            rxOvr <= 1'b1;
        end else if (wrTake && (wbReq_i.adr == ADDR_STATUS)) begin
            rxOvr <= 1'b0;
        end
    end

    assign cfg_o = '{period: period, roundUp: roundUp, roundDown: roundDown,
                     parEn: parEn, parOdd: parOdd, msbFirst: msbFirst,
                     loopback: loopback, txEn: txEn, rxEn: rxEn};

    // ----------------------------------------
    // Status and read mux
    // ----------------------------------------
    always_comb begin
        status = '0;
        // Head error flags only mean something when a word is there
        status[STAT_PAR_ERR]   = !rxEmpty_i && rxHead_i.parErr;
        status[STAT_FRAME_ERR] = !rxEmpty_i && rxHead_i.frameErr;
        status[STAT_TX_FULL]   = txFull_i;
        status[STAT_TX_EMPTY]  = txEmpty_i;
        status[STAT_RX_FULL]   = rxFull_i;
        status[STAT_RX_EMPTY]  = rxEmpty_i;
        status[STAT_RX_OVR]    = rxOvr;
    end

    always_comb begin
        case (wbReq_i.adr)
            ADDR_CONTROL:   rdMux = {4'b0000, rxEn, txEn, 2'b00};
            ADDR_MODE:      rdMux = {msbFirst, parEn, parOdd, 4'b0000, loopback};
            ADDR_BAUD_HIGH: rdMux = period[15:8];
            ADDR_BAUD_LOW:  rdMux = period[7:0];
            ADDR_COMP:      rdMux = {roundUp, roundDown};
            ADDR_STATUS:    rdMux = status;
            ADDR_RSVD:      rdMux = 8'h00;
            default:        rdMux = rxHead_i.data;
        endcase
    end

endmodule

/* hdl/uartTop.sv */
// UART controller top, Wishbone classic host side
// Local loopback holds txd_o high and feeds TX back into RX
`timescale 1ns/1ps

module uartTop import uartPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  wbReq_t wbReq_i,
    output wbRsp_t wbRsp_o,
    input  logic   rxd_i,
    output logic   txd_o
);

    uartCfg_t   cfg;
    // TX side
    logic       txPush;
    logic       txClr;
    logic [7:0] txData;
    logic [7:0] txHead;
    logic       txEmpty;
    logic       txFull;
    logic       txPop;
    logic       txRun;
    logic       txBitTick;
    logic       txSer;
    // RX side
    logic       rxPop;
    logic       rxClr;
    rxWord_t    rxHead;
    logic       rxEmpty;
    logic       rxFull;
    logic       rxPush;
    rxWord_t    rxWord;
    logic       rxDrop;
    logic       rxRun;
    logic       rxMidTick;
    logic       rxBitTick;
    logic       rxLine;

    // Loopback select
    assign rxLine = cfg.loopback ? txSer : rxd_i;
    assign txd_o  = cfg.loopback ? 1'b1 : txSer;
    // Word lost when the RX FIFO is full
    assign rxDrop = rxPush && rxFull;

    uartRegs regs (
        .clk, .rst, .wbReq_i, .wbRsp_o,
        .cfg_o     (cfg),
        .txPush_o  (txPush),
        .txClr_o   (txClr),
        .txData_o  (txData),
        .txFull_i  (txFull),
        .txEmpty_i (txEmpty),
        .rxPop_o   (rxPop),
        .rxClr_o   (rxClr),
        .rxHead_i  (rxHead),
        .rxEmpty_i (rxEmpty),
        .rxFull_i  (rxFull),
        .rxDrop_i  (rxDrop)
    );

    syncFifo #(.payload_t(logic [7:0]), .DEPTH(FIFO_DEPTH)) txFifo (
        .clk, .rst,
        .clr_i (txClr), .push_i (txPush), .data_i (txData),
        .pop_i (txPop), .head_o (txHead), .empty_o (txEmpty), .full_o (txFull)
    );

    syncFifo #(.payload_t(rxWord_t), .DEPTH(FIFO_DEPTH)) rxFifo (
        .clk, .rst,
        .clr_i (rxClr), .push_i (rxPush), .data_i (rxWord),
        .pop_i (rxPop), .head_o (rxHead), .empty_o (rxEmpty), .full_o (rxFull)
    );

    // TX only needs end-of-bit ticks
    baudGen txBaud (
        .clk, .rst,
        .run_i (txRun), .period_i (cfg.period),
        .roundUp_i (cfg.roundUp), .roundDown_i (cfg.roundDown),
        .midTick_o (), .bitTick_o (txBitTick)
    );

    baudGen rxBaud (
        .clk, .rst,
        .run_i (rxRun), .period_i (cfg.period),
        .roundUp_i (cfg.roundUp), .roundDown_i (cfg.roundDown),
        .midTick_o (rxMidTick), .bitTick_o (rxBitTick)
    );

    uartTx tx (
        .clk, .rst,
        .cfg_i (cfg), .fifoData_i (txHead), .fifoEmpty_i (txEmpty),
        .fifoPop_o (txPop), .bitTick_i (txBitTick), .run_o (txRun), .txd_o (txSer)
    );

    uartRx rx (
        .clk, .rst,
        .cfg_i (cfg), .rxd_i (rxLine), .midTick_i (rxMidTick), .bitTick_i (rxBitTick),
        .run_o (rxRun), .push_o (rxPush), .word_o (rxWord)
    );

endmodule

/* tests/uartTests.svh */
// Directed tests included inside the testbench module
// Each task leaves TX and RX disabled and both lines idle

task automatic readResetValues();
    logic [7:0] expected [7];
    logic [7:0] value;
    int         a;
    // Control, Mode, BaudHigh, BaudLow, Compensation, Status, reserved
    expected = '{8'h00, 8'h60, 8'h00, 8'h14, 8'hA5, 8'h0A, 8'h00};
    if (wbRsp.ack !== 1'b0) begin
        errorCount++;
        $display("Fail wbRsp.ack expected 0x0 got 0x%h", wbRsp.ack);
    end
    if (txd !== 1'b1) begin
        errorCount++;
        $display("Fail txd_o expected 0x1 got 0x%h", txd);
    end
    for (a = 0; a < 7; a++) begin
        wbRead(3'(a), value);
        compareByte($sformatf("wbRsp.dat reset register %0d", a), expected[a], value);
    end
endtask

task automatic writeReadRegisters();
    logic [2:0] adrs [4];
    logic [7:0] vals [4];
    logic [7:0] value;
    int         i;
    adrs = '{ADDR_MODE, ADDR_BAUD_HIGH, ADDR_BAUD_LOW, ADDR_COMP};
    vals = '{8'hE1, 8'h12, 8'h34, 8'h3C};
    for (i = 0; i < 4; i++) begin
        wbWrite(adrs[i], vals[i]);
        wbRead(adrs[i], value);
        compareByte($sformatf("wbRsp.dat register %0d", adrs[i]), vals[i], value);
    end
    // Clear bits act once and read back 0
    wbWrite(ADDR_CONTROL, 8'h0F);
    wbRead(ADDR_CONTROL, value);
    compareByte("wbRsp.dat Control", 8'h0C, value);
    wbWrite(ADDR_CONTROL, 8'h00);
    wbWrite(ADDR_MODE, RST_MODE);
endtask

// Six bytes through the loopback path in one mode
task automatic loopbackRun(input logic [7:0] mode);
    logic [7:0] sent [6];
    logic [7:0] status;
    logic [7:0] value;
    int         i;
    wbWrite(ADDR_MODE, mode);
    wbWrite(ADDR_CONTROL, 8'h0C);
    for (i = 0; i < 6; i++) begin
        sent[i] = nextByte();
        wbWrite(ADDR_DATA, sent[i]);
    end
    // Serializer is inside its first start bit here
    if (txd !== 1'b1) begin
        errorCount++;
        $display("Fail txd_o expected 0x1 got 0x%h", txd);
    end
    for (i = 0; i < 6; i++) begin
        waitRxData(status);
        compareByte("Status head error bits", 8'h00, status & 8'h60);
        wbRead(ADDR_DATA, value);
        compareByte("wbRsp.dat loopback data", sent[i], value);
    end
    // Last stop bit still on the line
    repeat (bitTime) @(posedge clk);
    wbWrite(ADDR_CONTROL, 8'h00);
endtask

task automatic loopbackModes();
    loopbackRun(8'h01);
    loopbackRun(8'hE1);
    loopbackRun(8'h41);
endtask

// One frame per mode checked bit by bit on txd_o
task automatic txLineFrames();
    logic [7:0] modes [3];
    logic [7:0] sent;
    logic [7:0] data;
    logic       startBit;
    logic       parBit;
    logic       stopBit;
    int         m;
    // MSB even, LSB odd, no parity
    modes = '{8'hC0, 8'h60, 8'h00};
    for (m = 0; m < 3; m++) begin
        wbWrite(ADDR_MODE, modes[m]);
        wbWrite(ADDR_CONTROL, 8'h04);
        sent = nextByte();
        wbWrite(ADDR_DATA, sent);
        recvSerial(modes[m][7], modes[m][6], startBit, data, parBit, stopBit);
        compareByte("txd_o start bit", 8'h00, startBit);
        compareByte("txd_o data bits", sent, data);
        if (modes[m][6]) begin
            compareByte("txd_o parity bit", parityBit(sent, modes[m][5]), parBit);
        end
        compareByte("txd_o stop bit", 8'h01, stopBit);
        repeat (bitTime) @(posedge clk);
        wbWrite(ADDR_CONTROL, 8'h00);
    end
endtask

task automatic rxErrorFlags();
    logic [7:0] sent;
    logic [7:0] status;
    logic [7:0] value;
    wbWrite(ADDR_MODE, 8'h60);
    wbWrite(ADDR_CONTROL, 8'h08);
    // Wrong parity, good stop
    sent = nextByte();
    sendSerial(sent, 1'b0, 1'b1, ~parityBit(sent, 1'b1), 1'b1);
    waitRxData(status);
    compareByte("Status head error bits", 8'h40, status & 8'h60);
    wbRead(ADDR_DATA, value);
    compareByte("wbRsp.dat parity error frame", sent, value);
    // Good parity, low stop
    sent = nextByte();
    sendSerial(sent, 1'b0, 1'b1, parityBit(sent, 1'b1), 1'b0);
    waitRxData(status);
    compareByte("Status head error bits", 8'h20, status & 8'h60);
    wbRead(ADDR_DATA, value);
    compareByte("wbRsp.dat framing error frame", sent, value);
    wbWrite(ADDR_CONTROL, 8'h00);
endtask

task automatic fifoLimits();
    logic [7:0] sent [9];
    logic [7:0] status;
    logic [7:0] value;
    int         i;
    // TX FIFO fills while TX is off
    // The ninth byte is lost
    wbWrite(ADDR_CONTROL, 8'h03);
    wbWrite(ADDR_MODE, 8'h61);
    for (i = 0; i < 9; i++) begin
        sent[i] = nextByte();
        wbWrite(ADDR_DATA, sent[i]);
    end
    wbRead(ADDR_STATUS, status);
    compareByte("Status with TX full", 8'h12, status);
    wbWrite(ADDR_CONTROL, 8'h0C);
    for (i = 0; i < 8; i++) begin
        waitRxData(status);
        wbRead(ADDR_DATA, value);
        compareByte("wbRsp.dat drained byte", sent[i], value);
    end
    repeat (2 * 11 * bitTime) @(posedge clk);
    wbRead(ADDR_STATUS, status);
    compareByte("Status after TX drain", 8'h0A, status);
    wbWrite(ADDR_CONTROL, 8'h00);

    // RX FIFO overrun from the line
    wbWrite(ADDR_MODE, 8'h60);
    wbWrite(ADDR_CONTROL, 8'h08);
    for (i = 0; i < 9; i++) begin
        sent[i] = nextByte();
        sendSerial(sent[i], 1'b0, 1'b1, parityBit(sent[i], 1'b1), 1'b1);
    end
    wbRead(ADDR_STATUS, status);
    compareByte("Status with RX overrun", 8'h0D, status);
    for (i = 0; i < 8; i++) begin
        wbRead(ADDR_DATA, value);
        compareByte("wbRsp.dat kept byte", sent[i], value);
    end
    wbRead(ADDR_STATUS, status);
    compareByte("Status after RX drain", 8'h0B, status);
    wbWrite(ADDR_STATUS, 8'h00);
    wbRead(ADDR_STATUS, status);
    compareByte("Status after overrun clear", 8'h0A, status);
    wbWrite(ADDR_CONTROL, 8'h00);
endtask

/* tests/tbUart.sv */
// Testbench for the UART controller, drives Wishbone and the serial line
// Bit time follows roundUp*(period+1) + roundDown*period clocks
// Directed tests come from the included uartTests.svh
`timescale 1ns/1ps

module tbUart import uartPkg::*; ();

    // Working baud setup used after the register tests
    localparam int BAUD_PERIOD = 6;
    localparam int BAUD_UP     = 3;
    localparam int BAUD_DOWN   = 2;
    localparam int BIT_CLKS    = BAUD_UP * (BAUD_PERIOD + 1) + BAUD_DOWN * BAUD_PERIOD;
    // Frames over all tests plus idle waits, 11 bits each, doubled for margin
    localparam int FRAME_COUNT = 48;
    localparam int MAX_CYCLES  = 2 * FRAME_COUNT * 11 * BIT_CLKS + 10000;

    logic        clk;
    logic        rst;
    wbReq_t      wbReq;
    wbRsp_t      wbRsp;
    logic        rxd;
    logic        txd;
    int          bitTime;
    int          errorCount = 0;
    int          cycleCount = 0;
    logic [31:0] lcgState = 32'd2;

    uartTop uut (
        .clk     (clk),
        .rst     (rst),
        .wbReq_i (wbReq),
        .wbRsp_o (wbRsp),
        .rxd_i   (rxd),
        .txd_o   (txd)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycleCount);
            $display("Errors: %0d", errorCount);
            $display("Something failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [7:0] nextByte();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];
    endfunction

    function automatic int bitClocks(int period, int up, int down);
        return up * (period + 1) + down * period;
    endfunction

    // Odd parity makes the total count of ones odd
    function automatic logic parityBit(logic [7:0] data, logic odd);
        return odd ? ~^data : ^data;
    endfunction

    task automatic compareByte(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    // Wishbone write, ack is a flop so it is seen 1 ns after the edge
    task automatic wbWrite(input logic [2:0] adr, input logic [7:0] dat);
        @(posedge clk);
        #1;
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do begin
            @(posedge clk);
            #1;
        end while (!wbRsp.ack);
        wbReq = '0;
    endtask

    task automatic wbRead(input logic [2:0] adr, output logic [7:0] dat);
        @(posedge clk);
        #1;
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
        do begin
            @(posedge clk);
            #1;
        end while (!wbRsp.ack);
        // Read data valid while ack is high
        dat   = wbRsp.dat;
        wbReq = '0;
    endtask

    task automatic setBaud(input int period, input int up, input int down);
        wbWrite(ADDR_BAUD_HIGH, period[15:8]);
        wbWrite(ADDR_BAUD_LOW, period[7:0]);
        wbWrite(ADDR_COMP, {up[3:0], down[3:0]});
        bitTime = bitClocks(period, up, down);
    endtask

    // Poll Status until the RX FIFO holds a word
    task automatic waitRxData(output logic [7:0] status);
        do begin
            wbRead(ADDR_STATUS, status);
        end while (status[STAT_RX_EMPTY]);
    endtask

    // ----------------------------------------
    // Serial line
    // ----------------------------------------
    task automatic holdLine(input logic level);
        rxd = level;
        repeat (bitTime) @(posedge clk);
        #1;
    endtask

    task automatic sendSerial(input logic [7:0] data, input logic msbFirst,
                              input logic parEn, input logic parBit, input logic stopBit);
        int i;
        @(posedge clk);
        #1;
        holdLine(1'b0);
        for (i = 0; i < 8; i++) begin
            holdLine(msbFirst ? data[7 - i] : data[i]);
        end
        if (parEn) begin
            holdLine(parBit);
        end
        holdLine(stopBit);
        // Back to idle even after a broken stop bit
        rxd = 1'b1;
    endtask

    // Samples txd_o at the middle of each bit, on falling clock edges
    task automatic recvSerial(input logic msbFirst, input logic parEn, output logic startBit,
                              output logic [7:0] data, output logic parBit,
                              output logic stopBit);
        int i;
        data   = '0;
        parBit = 1'b0;
        while (txd !== 1'b0) begin
            @(negedge clk);
        end
        repeat (bitTime / 2) @(negedge clk);
        startBit = txd;
        for (i = 0; i < 8; i++) begin
            repeat (bitTime) @(negedge clk);
            if (msbFirst) begin
                data[7 - i] = txd;
            end else begin
                data[i] = txd;
            end
        end
        if (parEn) begin
            repeat (bitTime) @(negedge clk);
            parBit = txd;
        end
        repeat (bitTime) @(negedge clk);
        stopBit = txd;
    endtask

    `include "uartTests.svh"

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        clk     = 1'b0;
        rst     = 1'b0;
        wbReq   = '0;
        rxd     = 1'b1;
        bitTime = bitClocks(RST_PERIOD, RST_ROUND_UP, RST_ROUND_DOWN);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;

        readResetValues();
        writeReadRegisters();
        setBaud(BAUD_PERIOD, BAUD_UP, BAUD_DOWN);
        loopbackModes();
        txLineFrames();
        rxErrorFlags();
        fifoLimits();

        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+tests
hdl/uartPkg.sv
hdl/syncFifo.sv
hdl/baudGen.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartRegs.sv
hdl/uartTop.sv
tests/tbUart.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal --top-module tbUart -f list.f -o VtbUart
	out=$$(./obj_dir/VtbUart); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
